// ==== rtl/bpu_macros.svh ====
`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// Width of every fetch address
`define XLEN 32

// Low PC bits that are always zero for 32-bit instructions
// Indexing and stored targets skip them
`define BPU_OFFSET 2

// Default global history length
// This is also the gshare index width
`define BPU_HLEN_DEF 4

// Default BTB index width, 2^N direct-mapped entries
`define BPU_BTB_BITS_DEF 4

`endif

// ==== rtl/core_pkg.sv ====
package core_pkg;

`include "bpu_macros.svh"

  // Plain byte address as seen by fetch
  typedef logic [`XLEN-1:0] addr_t;

endpackage

// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

  import core_pkg::*;

  // Two-bit saturating counter
  // Counting up means more confident in taken
  typedef enum logic [1:0] {
    SNT = 2'b00,
    WNT = 2'b01,
    WT  = 2'b10,
    ST  = 2'b11
  } c2b_t;

  // Outcome of one resolved branch from the branch unit
  typedef struct packed {
    addr_t pc;
    addr_t target;
    logic  taken;
    logic  mispredict;
  } resolution_t;

  // Prediction returned to fetch in the same cycle
  typedef struct packed {
    addr_t pc;
    logic  hit;
    logic  taken;
    addr_t target;
  } prediction_t;

endpackage

// ==== rtl/bpu_res_if.sv ====
`timescale 1ns/1ps

// One branch resolution, valid only in cycles where valid is high
interface bpu_res_if
  import core_pkg::*;
();

  logic  valid;
  addr_t pc;
  addr_t target;
  logic  taken;
  logic  mispredict;

  // Top level drives the resolution
  modport src (output valid, pc, target, taken, mispredict);

  // Direction predictor only needs the outcome and where it came from
  modport gsh (input valid, pc, taken);

  // BTB needs the full resolution
  modport btb (input valid, pc, target, taken, mispredict);

endinterface

// ==== rtl/pred_table.sv ====
`timescale 1ns/1ps

// Flip-flop table shared by the counters and the BTB entries
module pred_table #(
  parameter int unsigned DEPTH_BITS = 4,
  parameter type         entry_t    = logic [1:0],
  parameter entry_t      RESET_VAL  = entry_t'('0)
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  clear_i,
  input  logic [DEPTH_BITS-1:0] rd_idx_i,
  input  logic                  wr_en_i,
  input  logic [DEPTH_BITS-1:0] wr_idx_i,
  input  entry_t                wr_data_i,
  output entry_t                rd_data_o
);

  localparam int unsigned DEPTH = 1 << DEPTH_BITS;

  // Storage, one entry per index
  entry_t table_q [DEPTH];

  // Reset and clear load every entry, clear beats a write in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        table_q[i] <= RESET_VAL;
      end
    end else if (wr_en_i) begin
      // New value visible on the read port after this edge
      table_q[wr_idx_i] <= wr_data_i;
    end
  end

  // Combinational lookup
  assign rd_data_o = table_q[rd_idx_i];

endmodule

// ==== rtl/gshare.sv ====
`timescale 1ns/1ps

`include "bpu_macros.svh"

// Gshare direction predictor
module gshare
  import core_pkg::*;
  import fetch_pkg::*;
#(
  parameter int unsigned HLEN     = `BPU_HLEN_DEF,
  parameter c2b_t        INIT_C2B = WNT
) (
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          flush_i,
  input  addr_t         curr_pc_i,
  bpu_res_if.gsh        res,
  output logic          taken_o
);

  localparam int unsigned OFF = `BPU_OFFSET;

  logic [HLEN-1:0] hist_q;
  logic [HLEN-1:0] rd_idx;
  logic [HLEN-1:0] res_idx;
  c2b_t            rd_c2b;
  c2b_t            res_c2b;
  c2b_t            upd_c2b;

  // PC word bits hashed with the global history
  assign rd_idx  = curr_pc_i[OFF+HLEN-1:OFF] ^ hist_q;
  // Resolution is hashed with the same history that is current now
  assign res_idx = res.pc[OFF+HLEN-1:OFF] ^ hist_q;

  // Global history, newest outcome at bit 0
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      hist_q <= '0;
    end else if (res.valid) begin
      hist_q <= {hist_q[HLEN-2:0], res.taken};
    end
  end

  // Saturating counter step
  always_comb begin
    unique case (res_c2b)
      SNT:     upd_c2b = res.taken ? WNT : SNT;
      WNT:     upd_c2b = res.taken ? WT  : SNT;
      WT:      upd_c2b = res.taken ? ST  : WNT;
      default: upd_c2b = res.taken ? ST  : WT;
    endcase
  end

  // Lookup copy of the counters, read with the fetch PC
  pred_table #(
    .DEPTH_BITS(HLEN),
    .entry_t   (c2b_t),
    .RESET_VAL (INIT_C2B)
  ) u_pred_tab (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .clear_i  (flush_i),
    .rd_idx_i (rd_idx),
    .wr_en_i  (res.valid),
    .wr_idx_i (res_idx),
    .wr_data_i(upd_c2b),
    .rd_data_o(rd_c2b)
  );

  // Update copy with identical writes
  // gives the second read port for read-modify-write
  pred_table #(
    .DEPTH_BITS(HLEN),
    .entry_t   (c2b_t),
    .RESET_VAL (INIT_C2B)
  ) u_upd_tab (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .clear_i  (flush_i),
    .rd_idx_i (res_idx),
    .wr_en_i  (res.valid),
    .wr_idx_i (res_idx),
    .wr_data_i(upd_c2b),
    .rd_data_o(res_c2b)
  );

  // Upper counter bit is the direction
  assign taken_o = rd_c2b[1];

endmodule

// ==== rtl/btb.sv ====
`timescale 1ns/1ps

`include "bpu_macros.svh"

// Direct-mapped, fully tagged branch target buffer
module btb
  import core_pkg::*;
#(
  parameter int unsigned BTB_BITS = `BPU_BTB_BITS_DEF
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         flush_i,
  input  addr_t                        curr_pc_i,
  bpu_res_if.btb                       res,
  output logic                         hit_o,
  output logic [`XLEN-`BPU_OFFSET-1:0] target_o
);

  localparam int unsigned OFF   = `BPU_OFFSET;
  localparam int unsigned TAG_W = `XLEN - OFF - BTB_BITS;
  localparam int unsigned TGT_W = `XLEN - OFF;

  // Entry layout depends on BTB_BITS
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic [TGT_W-1:0] target;
  } btb_entry_t;

  logic [BTB_BITS-1:0] rd_idx;
  logic [BTB_BITS-1:0] wr_idx;
  logic [TAG_W-1:0]    rd_tag;
  logic                wr_en;
  btb_entry_t          wr_entry;
  btb_entry_t          rd_entry;

  // Index right above the offset, tag is everything higher
  assign rd_idx = curr_pc_i[OFF+BTB_BITS-1:OFF];
  assign rd_tag = curr_pc_i[`XLEN-1:OFF+BTB_BITS];
  assign wr_idx = res.pc[OFF+BTB_BITS-1:OFF];

  // Taken inserts
  // mispredicted not-taken deletes
  // correct not-taken leaves the entry alone
  assign wr_en = res.valid && (res.taken || res.mispredict);

  assign wr_entry.valid  = res.taken;
  assign wr_entry.tag    = res.pc[`XLEN-1:OFF+BTB_BITS];
  assign wr_entry.target = res.target[`XLEN-1:OFF];

  pred_table #(
    .DEPTH_BITS(BTB_BITS),
    .entry_t   (btb_entry_t),
    .RESET_VAL ('0)
  ) u_btb_tab (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .clear_i  (flush_i),
    .rd_idx_i (rd_idx),
    .wr_en_i  (wr_en),
    .wr_idx_i (wr_idx),
    .wr_data_i(wr_entry),
    .rd_data_o(rd_entry)
  );

  // Hit needs a live entry owned by this exact PC
  assign hit_o    = rd_entry.valid && (rd_entry.tag == rd_tag);
  assign target_o = rd_entry.target;

endmodule

// ==== rtl/bpu.sv ====
`timescale 1ns/1ps

`include "bpu_macros.svh"

// Branch prediction unit, gshare direction plus BTB target
module bpu
  import core_pkg::*;
  import fetch_pkg::*;
#(
  parameter int unsigned HLEN     = `BPU_HLEN_DEF,
  parameter int unsigned BTB_BITS = `BPU_BTB_BITS_DEF
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        flush_i,
  input  addr_t       curr_pc_i,
  input  logic        res_valid_i,
  input  addr_t       res_pc_i,
  input  addr_t       res_target_i,
  input  logic        res_taken_i,
  input  logic        res_mispredict_i,
  output prediction_t pred_o
);

  logic                         gsh_taken;
  logic                         btb_hit;
  logic [`XLEN-`BPU_OFFSET-1:0] btb_target;

  // Resolution bundle shared by both predictors
  bpu_res_if u_res_if ();

  assign u_res_if.valid      = res_valid_i;
  assign u_res_if.pc         = res_pc_i;
  assign u_res_if.target     = res_target_i;
  assign u_res_if.taken      = res_taken_i;
  assign u_res_if.mispredict = res_mispredict_i;

  // Direction
  gshare #(
    .HLEN    (HLEN),
    .INIT_C2B(WNT)
  ) u_gshare (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .flush_i  (flush_i),
    .curr_pc_i(curr_pc_i),
    .res      (u_res_if.gsh),
    .taken_o  (gsh_taken)
  );

  // Target
  btb #(
    .BTB_BITS(BTB_BITS)
  ) u_btb (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .flush_i  (flush_i),
    .curr_pc_i(curr_pc_i),
    .res      (u_res_if.btb),
    .hit_o    (btb_hit),
    .target_o (btb_target)
  );

  // Prediction is purely combinational from the current PC and table state
  assign pred_o.pc     = curr_pc_i;
  assign pred_o.hit    = btb_hit;
  assign pred_o.taken  = gsh_taken;
  // Stored target is word aligned, restore the zero offset bits
  assign pred_o.target = {btb_target, {`BPU_OFFSET{1'b0}}};

endmodule

// ==== test/tb_bpu.sv ====
`timescale 1ns/1ps

`include "bpu_macros.svh"

// Testbench for the branch prediction unit
module tb_bpu
  import core_pkg::*;
  import fetch_pkg::*;
();

  localparam int unsigned OFF   = `BPU_OFFSET;
  localparam int unsigned HLEN  = `BPU_HLEN_DEF;
  localparam int unsigned BBITS = `BPU_BTB_BITS_DEF;
  localparam int unsigned TAG_W = `XLEN - OFF - BBITS;

  logic        clk = 1'b0;
  logic        reset;
  logic        flush;
  addr_t       curr_pc;
  logic        res_valid;
  addr_t       res_pc;
  addr_t       res_target;
  logic        res_taken;
  logic        res_mispredict;
  prediction_t pred;

  // Reference model state
  c2b_t             m_ctr [1 << HLEN];
  logic [HLEN-1:0]  m_hist;
  logic             m_valid [1 << BBITS];
  logic [TAG_W-1:0] m_tag [1 << BBITS];
  addr_t            m_tgt [1 << BBITS];
  logic             model_ready = 1'b0;

  logic [31:0] lfsr;
  int          n_checks;
  int          n_mismatch;
  // Small PC pool, pool[3], pool[5] and pool[7] share an index with pool[0]
  addr_t       pool [8];

  bpu #(
    .HLEN    (HLEN),
    .BTB_BITS(BBITS)
  ) DUT (
    .clk_i           (clk),
    .reset_i         (reset),
    .flush_i         (flush),
    .curr_pc_i       (curr_pc),
    .res_valid_i     (res_valid),
    .res_pc_i        (res_pc),
    .res_target_i    (res_target),
    .res_taken_i     (res_taken),
    .res_mispredict_i(res_mispredict),
    .pred_o          (pred)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step for every bit drawn
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Expected prediction from the present model state
  function automatic prediction_t ref_predict(input addr_t pc);
    prediction_t      p;
    logic [HLEN-1:0]  gi;
    logic [BBITS-1:0] bi;
    gi       = pc[OFF+HLEN-1:OFF] ^ m_hist;
    bi       = pc[OFF+BBITS-1:OFF];
    p.pc     = pc;
    p.hit    = m_valid[bi] && (m_tag[bi] == pc[`XLEN-1:OFF+BBITS]);
    // Taken only in the two upper counter states
    p.taken  = (m_ctr[gi] == WT) || (m_ctr[gi] == ST);
    p.target = m_tgt[bi];
    return p;
  endfunction

  // Reset and flush state
  function automatic void model_clear();
    for (int i = 0; i < (1 << HLEN); i++) begin
      m_ctr[i] = WNT;
    end
    for (int i = 0; i < (1 << BBITS); i++) begin
      m_valid[i] = 1'b0;
      m_tag[i]   = '0;
      m_tgt[i]   = '0;
    end
    m_hist = '0;
  endfunction

  function automatic void model_resolve(input resolution_t r);
    logic [HLEN-1:0]  gi;
    logic [BBITS-1:0] bi;
    gi = r.pc[OFF+HLEN-1:OFF] ^ m_hist;
    bi = r.pc[OFF+BBITS-1:OFF];
    // Saturating step, with the history from before this branch
    if (r.taken && m_ctr[gi] != ST) begin
      m_ctr[gi] = c2b_t'(m_ctr[gi] + 1);
    end else if (!r.taken && m_ctr[gi] != SNT) begin
      m_ctr[gi] = c2b_t'(m_ctr[gi] - 1);
    end
    m_hist = {m_hist[HLEN-2:0], r.taken};
    if (r.taken) begin
      m_valid[bi] = 1'b1;
      m_tag[bi]   = r.pc[`XLEN-1:OFF+BBITS];
      m_tgt[bi]   = {r.target[`XLEN-1:OFF], {OFF{1'b0}}};
    end else if (r.mispredict) begin
      m_valid[bi] = 1'b0;
    end
  endfunction

  task automatic compare_pred(input string name, input prediction_t got, input prediction_t exp);
    n_checks++;
    if (got.pc !== exp.pc) begin
      n_mismatch++;
      $display("MISMATCH t=%0t %s.pc expected %h got %h", $time, name, exp.pc, got.pc);
    end
    if (got.hit !== exp.hit) begin
      n_mismatch++;
      $display("MISMATCH t=%0t %s.hit expected %b got %b", $time, name, exp.hit, got.hit);
    end
    if (got.taken !== exp.taken) begin
      n_mismatch++;
      $display("MISMATCH t=%0t %s.taken expected %b got %b", $time, name, exp.taken, got.taken);
    end
    // Target carries meaning only on a hit
    if (exp.hit && got.target !== exp.target) begin
      n_mismatch++;
      $display("MISMATCH t=%0t %s.target expected %h got %h", $time, name, exp.target,
               got.target);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, mismatches %0d", n_checks, n_mismatch);
    if (n_mismatch == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // Called at a falling edge, returns at the next one
  task automatic drive_cycle(input addr_t pc, input logic rv, input addr_t rpc,
                             input addr_t rtgt, input logic rtk, input logic rmp,
                             input logic fl);
    curr_pc        <= pc;
    res_valid      <= rv;
    res_pc         <= rpc;
    res_target     <= rtgt;
    res_taken      <= rtk;
    res_mispredict <= rmp;
    flush          <= fl;
    @(negedge clk);
  endtask

  task automatic lookup(input addr_t pc);
    drive_cycle(pc, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic resolve(input addr_t pc, input addr_t tgt, input logic tk, input logic mp);
    drive_cycle(pc, 1'b1, pc, tgt, tk, mp, 1'b0);
  endtask

  // Every pool PC should look like the reset state
  task automatic check_all_cold();
    foreach (pool[i]) begin
      lookup(pool[i]);
      compare_bit("pred_o.hit", pred.hit, 1'b0);
      compare_bit("pred_o.taken", pred.taken, 1'b0);
    end
  endtask

  // Model follows every rising edge, flush wins over a resolution
  always @(posedge clk) begin
    if (reset || flush) begin
      model_clear();
      model_ready = 1'b1;
    end else if (res_valid && model_ready) begin
      model_resolve({res_pc, res_target, res_taken, res_mispredict});
    end
  end

  // Compare every cycle before the next inputs land
  always @(negedge clk) begin
    if (model_ready) begin
      compare_pred("pred_o", pred, ref_predict(curr_pc));
    end
  end

  initial begin : stim
    prediction_t exp_p;
    logic [31:0] tgt;
    logic [31:0] pc_sel;
    logic [31:0] rpc_sel;
    logic [31:0] ctl;
    reset          = 1'b1;
    flush          = 1'b0;
    curr_pc        = '0;
    res_valid      = 1'b0;
    res_pc         = '0;
    res_target     = '0;
    res_taken      = 1'b0;
    res_mispredict = 1'b0;
    lfsr           = 32'heb6060f7;
    n_checks       = 0;
    n_mismatch     = 0;
    pool = '{32'h0000_1000, 32'h0000_1004, 32'h0000_1008, 32'h0000_1040,
             32'h0000_1044, 32'h0000_2000, 32'h0000_203c, 32'h8000_1000};
    repeat (16) @(negedge clk);
    reset <= 1'b0;
    check_all_cold();
    // Insert and train one branch, odd target low bits get dropped
    repeat (4) resolve(pool[0], 32'h0000_2345, 1'b1, 1'b0);
    lookup(pool[0]);
    exp_p = ref_predict(pool[0]);
    compare_bit("pred_o.hit", pred.hit, 1'b1);
    compare_bit("pred_o.target[1:0] nonzero", |pred.target[1:0], 1'b0);
    compare_bit("pred_o.taken", pred.taken, exp_p.taken);
    // Correct not-taken keeps the entry, mispredicted not-taken drops it
    resolve(pool[0], 32'h0000_0000, 1'b0, 1'b0);
    lookup(pool[0]);
    compare_bit("pred_o.hit", pred.hit, 1'b1);
    resolve(pool[0], 32'h0000_0000, 1'b0, 1'b1);
    lookup(pool[0]);
    compare_bit("pred_o.hit", pred.hit, 1'b0);
    // Alias on the same index with another tag
    resolve(pool[0], 32'h0000_3000, 1'b1, 1'b0);
    lookup(pool[3]);
    compare_bit("pred_o.hit", pred.hit, 1'b0);
    resolve(pool[3], 32'h0000_4004, 1'b1, 1'b1);
    lookup(pool[3]);
    compare_bit("pred_o.hit", pred.hit, 1'b1);
    lookup(pool[0]);
    compare_bit("pred_o.hit", pred.hit, 1'b0);
    // Flush together with a resolution
    resolve(pool[1], 32'h0000_5008, 1'b1, 1'b0);
    drive_cycle(pool[1], 1'b1, pool[2], 32'h0000_6000, 1'b1, 1'b0, 1'b1);
    check_all_cold();
    // Random mix, roughly one flush in 64 cycles
    for (int k = 0; k < 600; k++) begin
      draw(3, pc_sel);
      draw(3, rpc_sel);
      draw(32, tgt);
      draw(10, ctl);
      drive_cycle(pool[pc_sel[2:0]], |ctl[1:0], pool[rpc_sel[2:0]], tgt, ctl[2], ctl[3],
                  &ctl[9:4]);
    end
    lookup(pool[0]);
    finish_run();
  end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/fetch_pkg.sv
rtl/bpu_res_if.sv
rtl/pred_table.sv
rtl/gshare.sv
rtl/btb.sv
rtl/bpu.sv
test/tb_bpu.sv

// ==== Bender.yml ====
package:
  name: bpu

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_pkg.sv
      - rtl/fetch_pkg.sv
      - rtl/bpu_res_if.sv
      - rtl/pred_table.sv
      - rtl/gshare.sv
      - rtl/btb.sv
      - rtl/bpu.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_bpu.sv
